// File: flist.f
+incdir+verification
rtl/ctrlPkg.sv
rtl/stateSequencer.sv
rtl/instrDecoder.sv
rtl/branchUnit.sv
rtl/controlUnit.sv
verification/controlUnitTb.sv

// File: rtl/branchUnit.sv
module branchUnit
  import ctrlPkg::*;
(
  input  logic        clk,
  input  logic        arstN,
  input  logic        lastStep,
  input  branchKind_t branchKind,
  input  logic        outLsb,
  input  logic        lessThan,
  output logic        branchDelay
);

  logic taken;

  // outLsb carries the compare or sign-test result of EXEC1
  always_comb begin
    case (branchKind)
      BR_JUMP: taken = 1'b1;
      BR_EQ:   taken = outLsb;
      BR_NE:   taken = !outLsb;
      BR_GTZ:  taken = !outLsb;
      BR_LEZ:  taken = outLsb;
      BR_LTZ:  taken = lessThan;
      BR_GEZ:  taken = !lessThan;
      default: taken = 1'b0;
    endcase
  end

  // Loaded at the end of every instruction, so a plain one clears it
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      branchDelay <= 1'b0;
    end else if (lastStep) begin
      branchDelay <= taken;
    end
  end

endmodule

// File: rtl/controlUnit.sv
module controlUnit
  import ctrlPkg::*;
(
  input  logic       clk,
  input  logic       arstN,
  input  logic       start,
  input  logic       pcIsZero,
  input  logic       waitRequest,
  input  logic       aluStall,
  input  logic       outLsb,
  input  logic       lessThan,
  input  instrWord_t instr,
  output ctrlWord_t  ctrl,
  output memCtrl_t   mem,
  output cpuState_t  cpuState,
  output logic       active,
  output logic       branchDelay
);

  logic        lastStep;
  branchKind_t branchKind;

  stateSequencer uSequencer (
    .clk        (clk),
    .arstN      (arstN),
    .start      (start),
    .pcIsZero   (pcIsZero),
    .waitRequest(waitRequest),
    .aluStall   (aluStall),
    .lastStep   (lastStep),
    .cpuState   (cpuState)
  );

  instrDecoder uDecoder (
    .instr      (instr),
    .cpuState   (cpuState),
    .branchDelay(branchDelay),
    .ctrl       (ctrl),
    .mem        (mem),
    .lastStep   (lastStep),
    .branchKind (branchKind)
  );

  // Taken flag steers the next fetch through pcSrc
  branchUnit uBranch (
    .clk        (clk),
    .arstN      (arstN),
    .lastStep   (lastStep),
    .branchKind (branchKind),
    .outLsb     (outLsb),
    .lessThan   (lessThan),
    .branchDelay(branchDelay)
  );

  assign active = (cpuState != HALTED);

endmodule

// File: rtl/ctrlPkg.sv
package ctrlPkg;

  // Primary opcode field, bits 31:26
  typedef enum logic [5:0] {
    OP_RTYPE  = 6'b000000,
    OP_REGIMM = 6'b000001,
    OP_J      = 6'b000010,
    OP_JAL    = 6'b000011,
    OP_BEQ    = 6'b000100,
    OP_BNE    = 6'b000101,
    OP_BLEZ   = 6'b000110,
    OP_BGTZ   = 6'b000111,
    OP_ADDIU  = 6'b001001,
    OP_SLTI   = 6'b001010,
    OP_ANDI   = 6'b001100,
    OP_ORI    = 6'b001101,
    OP_XORI   = 6'b001110,
    OP_LUI    = 6'b001111,
    OP_LB     = 6'b100000,
    OP_LH     = 6'b100001,
    OP_LW     = 6'b100011,
    OP_LBU    = 6'b100100,
    OP_LHU    = 6'b100101,
    OP_SW     = 6'b101011
  } opcode_t;

  // R-type function field, bits 5:0
  typedef enum logic [5:0] {
    FN_JR   = 6'b001000,
    FN_ADDU = 6'b100001,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101
  } funct_t;

  // REGIMM branch group, selected by the rt field
  typedef enum logic [4:0] {
    RI_BLTZ = 5'b00000,
    RI_BGEZ = 5'b00001
  } regimm_t;

  typedef enum logic [2:0] {
    FETCH  = 3'b000,
    DECODE = 3'b001,
    EXEC1  = 3'b010,
    EXEC2  = 3'b011,
    EXEC3  = 3'b100,
    HALTED = 3'b101,
    STALL  = 3'b110
  } cpuState_t;

  typedef struct packed {
    opcode_t    opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    funct_t     funct;
  } rFormat_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iFormat_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [25:0] target;
  } jFormat_t;

  // One instruction word, three ways to read it
  typedef union packed {
    rFormat_t rFields;
    iFormat_t iFields;
    jFormat_t jFields;
  } instrWord_t;

  typedef enum logic [1:0] {
    SRCB_REG     = 2'b00,
    SRCB_FOUR    = 2'b01,
    SRCB_IMM     = 2'b10,
    SRCB_SHIFTED = 2'b11
  } aluSrcB_t;

  // Operation codes as the datapath ALU expects them
  typedef enum logic [4:0] {
    ALU_AND     = 5'b00000,
    ALU_OR      = 5'b00001,
    ALU_ADD     = 5'b00010,
    ALU_XOR     = 5'b00011,
    ALU_SLT     = 5'b00111,
    ALU_CMPEQ   = 5'b01010,
    ALU_SIGN    = 5'b01100,
    ALU_PASSA   = 5'b01110,
    ALU_REGOP   = 5'b01111,
    ALU_JUMPTGT = 5'b10001,
    ALU_LUI     = 5'b10100
  } aluOp_t;

  // Load data extension after the byte lanes are picked
  typedef enum logic [1:0] {
    EXT_ZERO     = 2'b00,
    EXT_SIGNBYTE = 2'b10,
    EXT_SIGNHALF = 2'b11
  } extendMode_t;

  typedef enum logic [2:0] {
    BR_NONE = 3'd0,
    BR_JUMP = 3'd1,
    BR_EQ   = 3'd2,
    BR_NE   = 3'd3,
    BR_GTZ  = 3'd4,
    BR_LEZ  = 3'd5,
    BR_LTZ  = 3'd6,
    BR_GEZ  = 3'd7
  } branchKind_t;

  typedef struct packed {
    logic     extSel;
    logic     aluSrcA;
    aluSrcB_t aluSrcB;
    aluOp_t   aluOp;
    logic     aluSel;
    logic     regWrite;
    logic     memToReg;
    logic     regDst;
    logic     pcWrite;
    logic     irWrite;
    logic     pcSrc;
    logic     isJump;
    logic     link;
  } ctrlWord_t;

  typedef struct packed {
    logic        read;
    logic        write;
    logic        iOrD;
    logic [3:0]  byteEnable;
    extendMode_t extendMode;
  } memCtrl_t;

  localparam logic [3:0] BE_WORD = 4'b1111;
  localparam logic [3:0] BE_HALF = 4'b0011;
  localparam logic [3:0] BE_BYTE = 4'b0001;

endpackage

// File: rtl/instrDecoder.sv
module instrDecoder
  import ctrlPkg::*;
(
  input  instrWord_t  instr,
  input  cpuState_t   cpuState,
  input  logic        branchDelay,
  output ctrlWord_t   ctrl,
  output memCtrl_t    mem,
  output logic        lastStep,
  output branchKind_t branchKind
);

  opcode_t     opcode;
  funct_t      funct;
  regimm_t     regimmCode;

  // Instruction class flags
  logic        isLoad;
  logic        isStore;
  logic        isAluR;
  logic        isJr;
  logic        isImmAlu;
  logic        isBranch;
  logic        isJ;
  logic        isJal;

  aluOp_t      immOp;
  logic        immExt;
  logic [3:0]  loadBe;
  extendMode_t loadExt;
  branchKind_t condKind;
  logic [1:0]  numSteps;

  assign opcode     = instr.iFields.opcode;
  assign funct      = instr.rFields.funct;
  assign regimmCode = regimm_t'(instr.iFields.rt);

  always_comb begin
    isLoad   = 1'b0;
    isStore  = 1'b0;
    isAluR   = 1'b0;
    isJr     = 1'b0;
    isImmAlu = 1'b0;
    isBranch = 1'b0;
    isJ      = 1'b0;
    isJal    = 1'b0;
    immOp    = ALU_ADD;
    immExt   = 1'b0;
    loadBe   = BE_WORD;
    loadExt  = EXT_ZERO;
    condKind = BR_NONE;
    case (opcode)
      OP_RTYPE: begin
        isAluR = funct inside {FN_ADDU, FN_AND, FN_OR};
        isJr   = (funct == FN_JR);
      end
      OP_LW: isLoad = 1'b1;
      OP_LH: begin
        isLoad  = 1'b1;
        loadBe  = BE_HALF;
        loadExt = EXT_SIGNHALF;
      end
      OP_LHU: begin
        isLoad = 1'b1;
        loadBe = BE_HALF;
      end
      OP_LB: begin
        isLoad  = 1'b1;
        loadBe  = BE_BYTE;
        loadExt = EXT_SIGNBYTE;
      end
      OP_LBU: begin
        isLoad = 1'b1;
        loadBe = BE_BYTE;
      end
      OP_SW: isStore = 1'b1;
      OP_ADDIU: isImmAlu = 1'b1;
      OP_SLTI: begin
        isImmAlu = 1'b1;
        immOp    = ALU_SLT;
      end
      // Logical immediates are zero extended
      OP_ANDI: begin
        isImmAlu = 1'b1;
        immOp    = ALU_AND;
        immExt   = 1'b1;
      end
      OP_ORI: begin
        isImmAlu = 1'b1;
        immOp    = ALU_OR;
        immExt   = 1'b1;
      end
      OP_XORI: begin
        isImmAlu = 1'b1;
        immOp    = ALU_XOR;
        immExt   = 1'b1;
      end
      OP_LUI: begin
        isImmAlu = 1'b1;
        immOp    = ALU_LUI;
      end
      OP_BEQ: begin
        isBranch = 1'b1;
        condKind = BR_EQ;
      end
      OP_BNE: begin
        isBranch = 1'b1;
        condKind = BR_NE;
      end
      OP_BGTZ: begin
        isBranch = 1'b1;
        condKind = BR_GTZ;
      end
      OP_BLEZ: begin
        isBranch = 1'b1;
        condKind = BR_LEZ;
      end
      OP_REGIMM: begin
        isBranch = regimmCode inside {RI_BLTZ, RI_BGEZ};
        condKind = (regimmCode == RI_BGEZ) ? BR_GEZ : BR_LTZ;
      end
      OP_J: isJ = 1'b1;
      OP_JAL: isJal = 1'b1;
      default: ;
    endcase
  end

  // Unknown encodings finish after one step as a no-op
  always_comb begin
    if (isLoad) begin
      numSteps = 2'd3;
    end else if (isAluR || isImmAlu || isStore || isJal) begin
      numSteps = 2'd2;
    end else begin
      numSteps = 2'd1;
    end
  end

  always_comb begin
    case (cpuState)
      EXEC1:   lastStep = (numSteps == 2'd1);
      EXEC2:   lastStep = (numSteps == 2'd2);
      EXEC3:   lastStep = 1'b1;
      default: lastStep = 1'b0;
    endcase
  end

  always_comb begin
    ctrl       = '0;
    mem        = '0;
    branchKind = BR_NONE;
    case (cpuState)
      HALTED: mem.byteEnable = BE_WORD;
      FETCH: begin
        mem.read       = 1'b1;
        mem.byteEnable = BE_WORD;
        ctrl.pcWrite   = 1'b1;
        if (branchDelay) begin
          ctrl.pcSrc = 1'b1;
        end else begin
          // PC + 4
          ctrl.aluSrcB = SRCB_FOUR;
          ctrl.aluOp   = ALU_ADD;
        end
      end
      STALL: begin
        mem.read       = 1'b1;
        mem.byteEnable = BE_WORD;
      end
      DECODE: begin
        ctrl.irWrite = 1'b1;
        // Precompute the branch target while registers are read
        ctrl.aluSrcB = SRCB_SHIFTED;
        ctrl.aluOp   = ALU_ADD;
      end
      EXEC1: begin
        if (isLoad || isStore) begin
          ctrl.aluSrcA = 1'b1;
          ctrl.aluSrcB = SRCB_IMM;
          ctrl.aluOp   = ALU_ADD;
        end else if (isImmAlu) begin
          ctrl.aluSrcA = 1'b1;
          ctrl.aluSrcB = SRCB_IMM;
          ctrl.aluOp   = immOp;
          ctrl.extSel  = immExt;
        end else if (isAluR) begin
          ctrl.aluSrcA = 1'b1;
          ctrl.aluSrcB = SRCB_REG;
          ctrl.aluOp   = ALU_REGOP;
        end else if (isJr) begin
          ctrl.aluSrcA = 1'b1;
          ctrl.aluOp   = ALU_PASSA;
          branchKind   = BR_JUMP;
        end else if (isBranch) begin
          ctrl.aluSrcA = 1'b1;
          ctrl.aluSel  = 1'b1;
          case (condKind)
            BR_EQ, BR_NE: ctrl.aluOp = ALU_CMPEQ;
            BR_GTZ:       ctrl.aluOp = ALU_SLT;
            default:      ctrl.aluOp = ALU_SIGN;
          endcase
          branchKind = condKind;
        end else if (isJ) begin
          ctrl.extSel  = 1'b1;
          ctrl.aluSrcB = SRCB_SHIFTED;
          ctrl.aluOp   = ALU_JUMPTGT;
          ctrl.isJump  = 1'b1;
          branchKind   = BR_JUMP;
        end else if (isJal) begin
          // Return address PC + 4 goes to r31
          ctrl.aluSrcB  = SRCB_FOUR;
          ctrl.aluOp    = ALU_ADD;
          ctrl.regWrite = 1'b1;
          ctrl.memToReg = 1'b1;
          ctrl.link     = 1'b1;
        end
      end
      EXEC2: begin
        if (isLoad) begin
          mem.read       = 1'b1;
          mem.iOrD       = 1'b1;
          mem.byteEnable = loadBe;
          mem.extendMode = loadExt;
          ctrl.aluSel    = 1'b1;
        end else if (isStore) begin
          mem.write      = 1'b1;
          mem.iOrD       = 1'b1;
          mem.byteEnable = BE_WORD;
        end else if (isAluR || isImmAlu) begin
          ctrl.aluSel   = 1'b1;
          ctrl.regDst   = isAluR;
          ctrl.memToReg = 1'b1;
          ctrl.regWrite = 1'b1;
        end else if (isJal) begin
          ctrl.extSel  = 1'b1;
          ctrl.aluSrcB = SRCB_SHIFTED;
          ctrl.aluOp   = ALU_JUMPTGT;
          ctrl.isJump  = 1'b1;
          branchKind   = BR_JUMP;
        end
      end
      EXEC3: begin
        if (isLoad) begin
          mem.extendMode = loadExt;
          ctrl.regWrite  = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

// File: rtl/stateSequencer.sv
module stateSequencer
  import ctrlPkg::*;
(
  input  logic      clk,
  input  logic      arstN,
  input  logic      start,
  input  logic      pcIsZero,
  input  logic      waitRequest,
  input  logic      aluStall,
  input  logic      lastStep,
  output cpuState_t cpuState
);

  cpuState_t nextState;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cpuState <= HALTED;
    end else begin
      cpuState <= nextState;
    end
  end

  always_comb begin
    nextState = cpuState;
    // A zero PC stops the core from any running state
    if (pcIsZero && cpuState != HALTED) begin
      nextState = HALTED;
    end else begin
      case (cpuState)
        HALTED: begin
          if (start) begin
            nextState = FETCH;
          end
        end
        FETCH, STALL: begin
          // Wait here until the instruction read completes
          if (waitRequest) begin
            nextState = STALL;
          end else begin
            nextState = DECODE;
          end
        end
        DECODE: begin
          nextState = EXEC1;
        end
        EXEC1: begin
          if (aluStall) begin
            nextState = EXEC1;
          end else if (lastStep) begin
            nextState = FETCH;
          end else begin
            nextState = EXEC2;
          end
        end
        EXEC2: begin
          // Data access back-pressure
          if (waitRequest) begin
            nextState = EXEC2;
          end else if (lastStep) begin
            nextState = FETCH;
          end else begin
            nextState = EXEC3;
          end
        end
        EXEC3: begin
          nextState = FETCH;
        end
        default: begin
          nextState = HALTED;
        end
      endcase
    end
  end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -f flist.f --top-module controlUnitTb

output=$(./obj_dir/VcontrolUnitTb)
echo "$output"

if echo "$output" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1

// File: verification/ctrlModel.svh
`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

// Inputs that steer the state machine in one cycle
typedef struct packed {
  logic start;
  logic pcIsZero;
  logic waitRequest;
  logic aluStall;
  logic outLsb;
  logic lessThan;
} stimIn_t;

typedef struct packed {
  logic regWrite;
  logic pcWrite;
  logic irWrite;
  logic pcSrc;
} strobes_t;

function automatic logic isLoadOp(input opcode_t op);
  return op inside {OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU};
endfunction

function automatic logic isAluClass(input instrWord_t word);
  opcode_t op;
  op = word.iFields.opcode;
  if (op == OP_RTYPE) begin
    return word.rFields.funct inside {FN_ADDU, FN_AND, FN_OR};
  end
  return op inside {OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
endfunction

// Execute steps per instruction class
function automatic int expSteps(input instrWord_t word);
  opcode_t op;
  op = word.iFields.opcode;
  if (isLoadOp(op)) begin
    return 3;
  end
  if (isAluClass(word) || op == OP_SW || op == OP_JAL) begin
    return 2;
  end
  return 1;
endfunction

function automatic logic isFinalStep(input cpuState_t state, input instrWord_t word);
  return (state == EXEC1 && expSteps(word) == 1) || (state == EXEC2 && expSteps(word) == 2) ||
         (state == EXEC3);
endfunction

function automatic cpuState_t expNextState(input cpuState_t state, input instrWord_t word,
                                           input stimIn_t inp);
  if (inp.pcIsZero && state != HALTED) begin
    return HALTED;
  end
  case (state)
    HALTED:       return inp.start ? FETCH : HALTED;
    FETCH, STALL: return inp.waitRequest ? STALL : DECODE;
    DECODE:       return EXEC1;
    EXEC1: begin
      if (inp.aluStall) begin
        return EXEC1;
      end
      return (expSteps(word) == 1) ? FETCH : EXEC2;
    end
    EXEC2: begin
      if (inp.waitRequest) begin
        return EXEC2;
      end
      return (expSteps(word) == 2) ? FETCH : EXEC3;
    end
    default:      return FETCH;
  endcase
endfunction

function automatic memCtrl_t expMem(input cpuState_t state, input instrWord_t word);
  memCtrl_t m;
  opcode_t op;
  m = '0;
  op = word.iFields.opcode;
  if (state == HALTED) begin
    m.byteEnable = BE_WORD;
  end
  if (state == FETCH || state == STALL) begin
    m.read = 1'b1;
    m.byteEnable = BE_WORD;
  end
  if (state == EXEC2 && op == OP_SW) begin
    m.write = 1'b1;
    m.iOrD = 1'b1;
    m.byteEnable = BE_WORD;
  end
  if (state == EXEC2 && isLoadOp(op)) begin
    m.read = 1'b1;
    m.iOrD = 1'b1;
    case (op)
      OP_LH, OP_LHU: m.byteEnable = BE_HALF;
      OP_LB, OP_LBU: m.byteEnable = BE_BYTE;
      default:       m.byteEnable = BE_WORD;
    endcase
  end
  if ((state == EXEC2 || state == EXEC3) && isLoadOp(op)) begin
    if (op == OP_LH) begin
      m.extendMode = EXT_SIGNHALF;
    end else if (op == OP_LB) begin
      m.extendMode = EXT_SIGNBYTE;
    end
  end
  return m;
endfunction

function automatic strobes_t expStrobes(input cpuState_t state, input instrWord_t word,
                                        input logic bd);
  strobes_t s;
  opcode_t op;
  op = word.iFields.opcode;
  s.pcWrite  = (state == FETCH);
  s.pcSrc    = (state == FETCH) && bd;
  s.irWrite  = (state == DECODE);
  s.regWrite = (state == EXEC3 && isLoadOp(op)) || (state == EXEC2 && isAluClass(word)) ||
               (state == EXEC1 && op == OP_JAL);
  return s;
endfunction

function automatic logic expTaken(input instrWord_t word, input logic lsb, input logic lt);
  case (word.iFields.opcode)
    OP_RTYPE:  return word.rFields.funct == FN_JR;
    OP_J:      return 1'b1;
    OP_JAL:    return 1'b1;
    OP_BEQ:    return lsb;
    OP_BNE:    return !lsb;
    OP_BGTZ:   return !lsb;
    OP_BLEZ:   return lsb;
    // rt selects BLTZ or BGEZ
    OP_REGIMM: begin
      if (word.iFields.rt == 5'd0) begin
        return lt;
      end
      return (word.iFields.rt == 5'd1) && !lt;
    end
    default:   return 1'b0;
  endcase
endfunction

`endif

// File: verification/controlUnitTb.sv
module controlUnitTb
  import ctrlPkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  `include "ctrlModel.svh"

  localparam int STEP_LIMIT = 200;

  logic       clk;
  logic       arstN;
  logic       start;
  logic       pcIsZero;
  logic       waitRequest;
  logic       aluStall;
  logic       outLsb;
  logic       lessThan;
  instrWord_t instr;
  ctrlWord_t  ctrl;
  memCtrl_t   mem;
  cpuState_t  cpuState;
  logic       active;
  logic       branchDelay;

  int         seed = 32'hf8f3;
  int         errors;
  int         timeouts;
  int         checks;
  bit         hung;
  string      testName;
  cpuState_t  modelState;
  logic       modelBd;

  // Kept instruction table
  string      names[$];
  opcode_t    ops[$];
  funct_t     fns[$];
  logic [4:0] rts[$];

  controlUnit uut (
    .clk        (clk),
    .arstN      (arstN),
    .start      (start),
    .pcIsZero   (pcIsZero),
    .waitRequest(waitRequest),
    .aluStall   (aluStall),
    .outLsb     (outLsb),
    .lessThan   (lessThan),
    .instr      (instr),
    .ctrl       (ctrl),
    .mem        (mem),
    .cpuState   (cpuState),
    .active     (active),
    .branchDelay(branchDelay)
  );

  always #2 clk = !clk;

  task automatic reportMismatch(input string what, input logic [31:0] expV,
                                input logic [31:0] gotV);
    $display("Error %s: %s expected %0h got %0h", testName, what, expV, gotV);
    errors++;
  endtask

  // Outputs are compared mid-cycle, then the model steps with this cycle's inputs
  always @(negedge clk) begin
    stimIn_t  now;
    strobes_t expS;
    strobes_t gotS;
    memCtrl_t expM;
    now = {start, pcIsZero, waitRequest, aluStall, outLsb, lessThan};
    if (!arstN) begin
      modelState = HALTED;
      modelBd = 1'b0;
    end else begin
      checks++;
      expM = expMem(modelState, instr);
      expS = expStrobes(modelState, instr, modelBd);
      gotS = {ctrl.regWrite, ctrl.pcWrite, ctrl.irWrite, ctrl.pcSrc};
      if (cpuState !== modelState) begin
        reportMismatch("cpuState", 32'(modelState), 32'(cpuState));
      end
      if (mem !== expM) begin
        reportMismatch("mem", 32'(expM), 32'(mem));
      end
      if (gotS !== expS) begin
        reportMismatch("strobes", 32'(expS), 32'(gotS));
      end
      if (branchDelay !== modelBd) begin
        reportMismatch("branchDelay", 32'(modelBd), 32'(branchDelay));
      end
      if (active !== (modelState != HALTED)) begin
        reportMismatch("active", 32'(modelState != HALTED), 32'(active));
      end
      if (modelState == HALTED && ctrl !== '0) begin
        reportMismatch("ctrl in HALTED", 0, 32'(ctrl));
      end
      if (isFinalStep(modelState, instr)) begin
        modelBd = expTaken(instr, outLsb, lessThan);
      end
      modelState = expNextState(modelState, instr, now);
    end
  end

  task automatic addKept(input string name, input opcode_t op, input funct_t fn,
                         input logic [4:0] rt);
    names.push_back(name);
    ops.push_back(op);
    fns.push_back(fn);
    rts.push_back(rt);
  endtask

  // Random register fields around a fixed opcode
  function automatic instrWord_t makeInstr(input opcode_t op, input funct_t fn,
                                           input logic [4:0] rt);
    logic [31:0] raw;
    instrWord_t  w;
    raw = $random(seed);
    w = raw;
    w.iFields.opcode = op;
    if (op == OP_RTYPE) begin
      w.rFields.funct = fn;
    end
    if (op == OP_REGIMM) begin
      w.iFields.rt = rt;
    end
    return w;
  endfunction

  task automatic driveRandom(input bit withStalls);
    waitRequest <= withStalls && (($random(seed) & 3) == 0);
    aluStall    <= withStalls && (($random(seed) & 3) == 0);
    outLsb      <= (($random(seed) & 1) == 1);
    lessThan    <= (($random(seed) & 1) == 1);
  endtask

  // Called at a falling edge
  task automatic waitForState(input cpuState_t target, input string what);
    int cycles;
    cycles = 0;
    while (cpuState != target && !hung) begin
      @(negedge clk);
      cycles++;
      if (cycles > STEP_LIMIT) begin
        $display("Timeout in %s: state %s never reached within %0d cycles", what,
                 target.name(), STEP_LIMIT);
        timeouts++;
        hung = 1'b1;
      end
    end
  endtask

  task automatic restart(input string name);
    if (hung) begin
      return;
    end
    testName = name;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    waitForState(FETCH, name);
  endtask

  // One instruction from FETCH back to FETCH
  task automatic runInstr(input string name, input instrWord_t word, input bit withStalls);
    int cycles;
    int execCycles;
    if (hung) begin
      return;
    end
    testName = name;
    cycles = 0;
    execCycles = 0;
    @(posedge clk);
    instr <= word;
    driveRandom(withStalls);
    @(negedge clk);
    while (cpuState != FETCH && cpuState != HALTED && !hung) begin
      if (cpuState inside {EXEC1, EXEC2, EXEC3}) begin
        execCycles++;
      end
      @(posedge clk);
      driveRandom(withStalls);
      @(negedge clk);
      cycles++;
      if (cycles > STEP_LIMIT) begin
        $display("Timeout in %s: instruction never returned to FETCH", name);
        timeouts++;
        hung = 1'b1;
      end
    end
    if (!withStalls && !hung && execCycles != expSteps(word)) begin
      reportMismatch("execute steps", expSteps(word), execCycles);
    end
  endtask

  task automatic haltMid(input string name, input instrWord_t word, input int delay);
    if (hung) begin
      return;
    end
    testName = name;
    @(posedge clk);
    instr <= word;
    driveRandom(1'b0);
    repeat (delay) begin
      @(posedge clk);
      driveRandom(1'b0);
    end
    @(posedge clk);
    pcIsZero <= 1'b1;
    @(posedge clk);
    pcIsZero <= 1'b0;
    @(negedge clk);
    waitForState(HALTED, name);
    restart(name);
  endtask

  initial begin
    int pick;
    clk = 1'b0;
    arstN = 1'b0;
    start = 1'b0;
    pcIsZero = 1'b0;
    waitRequest = 1'b0;
    aluStall = 1'b0;
    outLsb = 1'b0;
    lessThan = 1'b0;
    instr = '0;
    errors = 0;
    timeouts = 0;
    checks = 0;
    hung = 1'b0;
    testName = "reset";
    addKept("ADDU", OP_RTYPE, FN_ADDU, 5'd0);
    addKept("J", OP_J, FN_ADDU, 5'd0);
    addKept("AND", OP_RTYPE, FN_AND, 5'd0);
    addKept("JR", OP_RTYPE, FN_JR, 5'd0);
    addKept("OR", OP_RTYPE, FN_OR, 5'd0);
    addKept("BEQ", OP_BEQ, FN_ADDU, 5'd0);
    addKept("ADDIU", OP_ADDIU, FN_ADDU, 5'd0);
    addKept("BNE", OP_BNE, FN_ADDU, 5'd0);
    addKept("ANDI", OP_ANDI, FN_ADDU, 5'd0);
    addKept("BGTZ", OP_BGTZ, FN_ADDU, 5'd0);
    addKept("ORI", OP_ORI, FN_ADDU, 5'd0);
    addKept("BLEZ", OP_BLEZ, FN_ADDU, 5'd0);
    addKept("XORI", OP_XORI, FN_ADDU, 5'd0);
    addKept("BLTZ", OP_REGIMM, FN_ADDU, 5'd0);
    addKept("SLTI", OP_SLTI, FN_ADDU, 5'd0);
    addKept("BGEZ", OP_REGIMM, FN_ADDU, 5'd1);
    addKept("LUI", OP_LUI, FN_ADDU, 5'd0);
    addKept("JAL", OP_JAL, FN_ADDU, 5'd0);
    addKept("LW", OP_LW, FN_ADDU, 5'd0);
    addKept("LH", OP_LH, FN_ADDU, 5'd0);
    addKept("LHU", OP_LHU, FN_ADDU, 5'd0);
    addKept("LB", OP_LB, FN_ADDU, 5'd0);
    addKept("LBU", OP_LBU, FN_ADDU, 5'd0);
    addKept("SW", OP_SW, FN_ADDU, 5'd0);
    repeat (10) @(posedge clk);
    arstN <= 1'b1;
    repeat (4) @(negedge clk);
    restart("start from reset");
    // Every kept instruction twice with waits off
    repeat (2) begin
      for (int i = 0; i < names.size(); i++) begin
        runInstr(names[i], makeInstr(ops[i], fns[i], rts[i]), 1'b0);
      end
    end
    // Random order under memory and ALU stalls
    for (int n = 0; n < 120; n++) begin
      pick = {$random(seed)} % names.size();
      runInstr(names[pick], makeInstr(ops[pick], fns[pick], rts[pick]), 1'b1);
    end
    haltMid("halt in LW", makeInstr(OP_LW, FN_ADDU, 5'd0), 1);
    haltMid("halt in JAL", makeInstr(OP_JAL, FN_ADDU, 5'd0), 1);
    haltMid("halt in BEQ", makeInstr(OP_BEQ, FN_ADDU, 5'd0), 0);
    runInstr("ADDU after halt", makeInstr(OP_RTYPE, FN_ADDU, 5'd0), 1'b0);
    runInstr("SW after halt", makeInstr(OP_SW, FN_ADDU, 5'd0), 1'b1);
    @(posedge clk);
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
